/* src.f */
bus_pkg.sv
slave_pkg.sv
slave_in_port.sv
slave_out_port.sv
slave_port.sv
slave_mem.sv
bus_slave_top.sv
bus_slave_assertions.sv
tb_bus_slave.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_bus_slave -Mdir obj_dir -o sim_bus_slave

run: compile
	./obj_dir/sim_bus_slave +verilator+error+limit+100

clean:
	rm -rf obj_dir

/* tb_bus_slave.sv */
// Testbench with serial master, xorshift stimulus, model memory, timeout and result
`timescale 1ns/1ps

module tb_bus_slave
	import bus_pkg::*;
();

	localparam logic [addr_width-1:0] window_base = 12'hff4;	// Crosses the top of memory
	localparam int window_len = 24;
	localparam int max_cycles = 40000;	// Tests need roughly 5000

	logic clk;
	logic reset;
	logic [delay_width-1:0] slave_delay;
	logic read_en;
	logic write_en;
	logic master_valid;
	logic master_ready;
	logic rx_address;
	logic rx_data;
	logic rx_burst;
	logic slave_ready;
	logic slave_valid;
	logic split_en;
	logic tx_data;
	logic [31:0] rng;
	logic [data_width-1:0] model [0:(1 << addr_width)-1];
	int cycles = 0;

	bus_slave_top DUT (
		.clk(clk),
		.reset(reset),
		.slave_delay(slave_delay),
		.read_en(read_en),
		.write_en(write_en),
		.master_valid(master_valid),
		.master_ready(master_ready),
		.rx_address(rx_address),
		.rx_data(rx_data),
		.rx_burst(rx_burst),
		.slave_ready(slave_ready),
		.slave_valid(slave_valid),
		.split_en(split_en),
		.tx_data(tx_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk)
	begin
		cycles <= cycles + 1;
		if (DUT.u_slave_port.u_assertions.error_count != 0)
		begin
			$display("a slave port assertion failed at %0t", $time);
			$display("sim failed");
			$fatal(1);
		end
		else if (cycles >= max_cycles)
		begin
			$display("timeout, transactions did not finish within %0d cycles", max_cycles);
			$display("sim failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Serializes one frame LSB first once the slave is ready
	task automatic send_frame(input logic is_read, input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data, input logic [burst_width-1:0] burst,
		input logic [delay_width-1:0] delay);
		int i;
		@(negedge clk);
		while (!slave_ready)
			@(negedge clk);
		@(posedge clk);
		slave_delay <= delay;
		master_valid <= 1'b1;
		read_en <= is_read;
		write_en <= ~is_read;
		for (i = 0; i < addr_width; i++)
		begin
			rx_address <= addr[i];
			rx_burst <= burst[i];
			rx_data <= (i < data_width) ? data[i] : 1'b0;
			@(posedge clk);
			master_valid <= 1'b0;	// Only the start cycle is valid
			read_en <= 1'b0;
			write_en <= 1'b0;
		end
		rx_address <= 1'b0;
		rx_burst <= 1'b0;
		rx_data <= 1'b0;
	endtask

	task automatic write_byte(input logic [addr_width-1:0] addr,
		input logic [data_width-1:0] data, input logic [delay_width-1:0] delay);
		send_frame(1'b0, addr, data, '0, delay);
		model[addr] = data;
	endtask

	// Tries a start while busy, stalls a random time, takes the offer and collects eight bits
	task automatic receive_byte(output logic [data_width-1:0] value);
		int stall;
		int i;
		@(negedge clk);
		while (!slave_valid)
			@(negedge clk);
		@(posedge clk);
		master_valid <= 1'b1;	// Slave is busy, this start must be ignored
		write_en <= 1'b1;
		@(posedge clk);
		master_valid <= 1'b0;
		write_en <= 1'b0;
		rng = xorshift(rng);
		stall = int'(rng[2:0]);
		repeat (stall) @(negedge clk);
		@(posedge clk);
		master_ready <= 1'b1;
		@(posedge clk);
		master_ready <= 1'b0;	// Byte loads on this edge
		for (i = 0; i < data_width; i++)
		begin
			@(negedge clk);
			value[i] = tx_data;
		end
		@(negedge clk);	// Done pulse cycle
	endtask

	task automatic read_burst(input logic [addr_width-1:0] addr,
		input logic [burst_width-1:0] burst, input logic [delay_width-1:0] delay);
		int beats;
		int n;
		logic [addr_width-1:0] a;
		logic [data_width-1:0] got;
		beats = (burst == '0) ? 1 : int'(burst);
		send_frame(1'b1, addr, '0, burst, delay);
		for (n = 0; n < beats; n++)
		begin
			a = addr + addr_width'(n);	// Wraps at 4096
			receive_byte(got);
			if (got !== model[a])
			begin
				$display("MISMATCH time=%0t signal=tx_data addr=%03h expected=%02h received=%02h",
					$time, a, model[a], got);
				$display("sim failed");
				$fatal(1);
			end
		end
	endtask

	initial
	begin
		int i;
		int offset;
		int max_beats;
		logic [addr_width-1:0] addr;
		logic [burst_width-1:0] burst;
		logic [delay_width-1:0] delay;
		reset = 1'b1;
		slave_delay = '0;
		read_en = 1'b0;
		write_en = 1'b0;
		master_valid = 1'b0;
		master_ready = 1'b0;
		rx_address = 1'b0;
		rx_data = 1'b0;
		rx_burst = 1'b0;
		rng = 32'h462d;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		for (i = 0; i < window_len; i++)
		begin
			rng = xorshift(rng);
			write_byte(window_base + addr_width'(i), rng[7:0], delay_width'(rng[15:8] % 8'd13));
		end

		// Write then read back the same byte
		for (i = 0; i < 12; i++)
		begin
			rng = xorshift(rng);
			offset = rng % window_len;
			addr = window_base + addr_width'(offset);
			write_byte(addr, rng[15:8], delay_width'(rng[23:16] % 8'd13));
			read_burst(addr, burst_width'(1), delay_width'(rng[31:24] % 8'd13));
		end

		read_burst(window_base + 12'd3, '0, 6'd7);	// Count 0 gives one byte
		read_burst(12'hffc, 12'd8, 6'd2);

		for (i = 0; i < 16; i++)
		begin
			rng = xorshift(rng);
			offset = rng % window_len;
			max_beats = (window_len - offset > 12) ? 12 : window_len - offset;
			burst = burst_width'(rng[15:8] % 8'(max_beats + 1));
			delay = delay_width'(rng[23:16] % 8'd13);
			read_burst(window_base + addr_width'(offset), burst, delay);
		end

		@(negedge clk);
		if (DUT.u_slave_port.u_assertions.error_count == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule

/* bus_slave_assertions.sv */
// Concurrent assertions on reset, handshake, split and read offer rules, bound to slave_port
`timescale 1ns/1ps

module bus_slave_assertions
	import bus_pkg::*, slave_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [delay_width-1:0] slave_delay,
	input logic read_en,
	input logic write_en,
	input logic master_valid,
	input logic master_ready,
	input logic slave_ready,
	input logic slave_valid,
	input logic split_en,
	input logic tx_data,
	input logic in_ready,
	input logic out_ready,
	input logic rx_done,
	input logic [data_width-1:0] rdata,
	input ctrl_state_t state,
	input rx_frame_t frame
);

	int unsigned error_count = 0;	// Count of failed checks
	logic start;
	logic [delay_width-1:0] split_len;

	assign start = master_valid & slave_ready & (read_en | write_en);

	// Length of the current run of split cycles
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			split_len <= '0;
		else if (split_en)
			split_len <= split_len + 1'b1;
		else
			split_len <= '0;
	end

	a_reset_values: assert property (@(posedge clk)
		$fell(reset) |-> slave_ready && !slave_valid && !split_en)
	else
	begin
		error_count++;
		$error("slave outputs do not hold their reset values");
	end

	a_split_cause: assert property (@(posedge clk) disable iff (reset)
		$rose(split_en) |-> frame.read && slave_delay >= split_threshold)
	else
	begin
		error_count++;
		$error("split_en rose for a write or a fast read");
	end

	a_split_taken: assert property (@(posedge clk) disable iff (reset)
		rx_done && frame.read && slave_delay >= split_threshold |=> split_en)
	else
	begin
		error_count++;
		$error("slow read did not raise split_en");
	end

	a_split_length: assert property (@(posedge clk) disable iff (reset)
		$fell(split_en) |-> split_len == slave_delay)
	else
	begin
		error_count++;
		$error("split_en length differs from slave_delay");
	end

	// One fetch cycle separates the split from the offer
	a_split_then_fetch: assert property (@(posedge clk) disable iff (reset)
		$fell(split_en) |-> !slave_valid ##1 slave_valid)
	else
	begin
		error_count++;
		$error("slave_valid did not rise one fetch cycle after split_en fell");
	end

	a_ready_drops: assert property (@(posedge clk) disable iff (reset)
		start |=> !slave_ready)
	else
	begin
		error_count++;
		$error("slave_ready stayed high after a frame start");
	end

	a_frame_taken: assert property (@(posedge clk) disable iff (reset)
		start |-> ##13 (state != ctrl_idle))
	else
	begin
		error_count++;
		$error("controller did not take the received frame");
	end

	// Ready returns only after the last read byte or the write cycle
	a_ready_at_end: assert property (@(posedge clk) disable iff (reset)
		$rose(slave_ready) |-> $fell(slave_valid) || (frame.write && $past(rx_done, 2)))
	else
	begin
		error_count++;
		$error("slave_ready rose before the transaction finished");
	end

	a_start_when_ready: assert property (@(posedge clk) disable iff (reset)
		$fell(in_ready) |-> $past(start))
	else
	begin
		error_count++;
		$error("frame accepted while slave_ready was low");
	end

	// Offer held with a quiet line until the master takes it
	a_hold_offer: assert property (@(posedge clk) disable iff (reset)
		slave_valid && !master_ready && out_ready |-> !tx_data ##1 (slave_valid && $stable(rdata)))
	else
	begin
		error_count++;
		$error("read byte offer not held while master_ready was low");
	end

endmodule

bind slave_port bus_slave_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.slave_delay(slave_delay),
	.read_en(read_en),
	.write_en(write_en),
	.master_valid(master_valid),
	.master_ready(master_ready),
	.slave_ready(slave_ready),
	.slave_valid(slave_valid),
	.split_en(split_en),
	.tx_data(tx_data),
	.in_ready(in_ready),
	.out_ready(out_ready),
	.rx_done(rx_done),
	.rdata(rdata),
	.state(state),
	.frame(frame)
);

/* bus_slave_top.sv */
// Bus slave top level with slave port and byte memory
`timescale 1ns/1ps

module bus_slave_top
	import bus_pkg::*, slave_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [delay_width-1:0] slave_delay,
	input logic read_en,
	input logic write_en,
	input logic master_valid,
	input logic master_ready,
	input logic rx_address,
	input logic rx_data,
	input logic rx_burst,
	output logic slave_ready,
	output logic slave_valid,
	output logic split_en,
	output logic tx_data
);

	mem_req_t mem_req;
	logic [data_width-1:0] rdata;

	slave_port u_slave_port (
		.clk(clk),
		.reset(reset),
		.slave_delay(slave_delay),
		.read_en(read_en),
		.write_en(write_en),
		.master_valid(master_valid),
		.master_ready(master_ready),
		.rx_address(rx_address),
		.rx_data(rx_data),
		.rx_burst(rx_burst),
		.rdata(rdata),
		.slave_ready(slave_ready),
		.slave_valid(slave_valid),
		.split_en(split_en),
		.tx_data(tx_data),
		.mem_req(mem_req)
	);

	slave_mem u_slave_mem (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.rdata(rdata)
	);

endmodule

/* slave_mem.sv */
// Byte memory with synchronous write and registered read
`timescale 1ns/1ps

module slave_mem
	import bus_pkg::*, slave_pkg::*;
(
	input logic clk,
	input logic reset,
	input mem_req_t mem_req,
	output logic [data_width-1:0] rdata
);

	logic [data_width-1:0] mem [0:(1 << addr_width)-1];

	always_ff @(posedge clk)
	begin
		if (mem_req.we)
			mem[mem_req.addr] <= mem_req.wdata;
	end

	// Read data holds until the next strobe
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rdata <= '0;
		else if (mem_req.re)
			rdata <= mem[mem_req.addr];
	end

endmodule

/* slave_port.sv */
// Slave controller with split wait, burst sequencing, memory requests and both ports
`timescale 1ns/1ps

module slave_port
	import bus_pkg::*, slave_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [delay_width-1:0] slave_delay,
	input logic read_en,
	input logic write_en,
	input logic master_valid,
	input logic master_ready,
	input logic rx_address,
	input logic rx_data,
	input logic rx_burst,
	input logic [data_width-1:0] rdata,
	output logic slave_ready,
	output logic slave_valid,
	output logic split_en,
	output logic tx_data,
	output mem_req_t mem_req
);

	rx_frame_t frame;
	logic rx_done;
	logic in_ready;
	logic out_ready;
	logic slave_tx_done;
	ctrl_state_t state;
	logic [delay_width-1:0] split_cnt;
	logic [addr_width-1:0] cur_addr;
	logic [burst_width-1:0] beats_left;

	assign slave_ready = in_ready & out_ready & (state == ctrl_idle);
	assign slave_valid = (state == ctrl_valid) | (state == ctrl_burst_end);
	assign split_en = (state == ctrl_split);

	// Fetch is the only cycle that touches memory, write or read
	assign mem_req = '{addr: cur_addr, wdata: frame.data,
		we: (state == ctrl_fetch) & frame.write,
		re: (state == ctrl_fetch) & frame.read};

	slave_in_port u_in_port (
		.clk(clk),
		.reset(reset),
		.master_valid(master_valid),
		.read_en(read_en),
		.write_en(write_en),
		.rx_address(rx_address),
		.rx_data(rx_data),
		.rx_burst(rx_burst),
		.busy(~slave_ready),
		.in_ready(in_ready),
		.frame(frame),
		.rx_done(rx_done)
	);

	slave_out_port u_out_port (
		.clk(clk),
		.reset(reset),
		.slave_valid(slave_valid),
		.master_ready(master_ready),
		.tx_byte(rdata),	// Registered in memory, stable while offered
		.tx_data(tx_data),
		.slave_tx_done(slave_tx_done),
		.out_ready(out_ready)
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= ctrl_idle;
			split_cnt <= '0;
			cur_addr <= '0;
			beats_left <= '0;
		end
		else
		begin
			case (state)
				ctrl_idle:
				begin
					if (rx_done)
					begin
						cur_addr <= frame.address;
						beats_left <= (frame.burst == '0) ? burst_width'(1) : frame.burst;
						split_cnt <= delay_width'(1);
						if (frame.read && slave_delay >= split_threshold)
							state <= ctrl_split;
						else
							state <= ctrl_fetch;
					end
				end
				ctrl_split:
				begin
					// split_en lasts slave_delay cycles
					if (split_cnt >= slave_delay)
						state <= ctrl_fetch;
					else
						split_cnt <= split_cnt + 1'b1;
				end
				ctrl_fetch:
				begin
					if (frame.write)
						state <= ctrl_idle;
					else if (beats_left == burst_width'(1))
						state <= ctrl_burst_end;
					else
						state <= ctrl_valid;
				end
				ctrl_valid:
				begin
					if (slave_tx_done)
					begin
						cur_addr <= cur_addr + 1'b1;	// Wraps at top of memory
						beats_left <= beats_left - 1'b1;
						state <= ctrl_fetch;
					end
				end
				ctrl_burst_end:
				begin
					if (slave_tx_done)
						state <= ctrl_idle;
				end
				default: state <= ctrl_idle;
			endcase
		end
	end

endmodule

/* slave_out_port.sv */
// Serial byte transmitter with valid/ready load and done pulse
`timescale 1ns/1ps

module slave_out_port
	import bus_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic slave_valid,
	input logic master_ready,
	input logic [data_width-1:0] tx_byte,
	output logic tx_data,
	output logic slave_tx_done,
	output logic out_ready
);

	logic load;
	logic shifting;
	logic [$clog2(data_width):0] bit_cnt;
	logic [data_width-1:0] shift_reg;

	// No reload in the done cycle, slave_valid is still high there
	assign out_ready = ~shifting & ~slave_tx_done;
	assign load = slave_valid & master_ready & out_ready;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			shifting <= 1'b0;
			bit_cnt <= '0;
			tx_data <= 1'b0;
			slave_tx_done <= 1'b0;
		end
		else
		begin
			slave_tx_done <= 1'b0;
			if (shifting)
			begin
				if (bit_cnt == data_width)
				begin
					shifting <= 1'b0;
					tx_data <= 1'b0;	// Line rests low
					slave_tx_done <= 1'b1;
				end
				else
				begin
					tx_data <= shift_reg[0];
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
			else if (load)
			begin
				shifting <= 1'b1;
				bit_cnt <= 1;
				tx_data <= tx_byte[0];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shift_reg <= tx_byte >> 1;
		else if (shifting)
			shift_reg <= shift_reg >> 1;
	end

endmodule

/* slave_in_port.sv */
// Serial frame receiver with start detect, shift registers and done pulse
`timescale 1ns/1ps

module slave_in_port
	import bus_pkg::*, slave_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic master_valid,
	input logic read_en,
	input logic write_en,
	input logic rx_address,
	input logic rx_data,
	input logic rx_burst,
	input logic busy,
	output logic in_ready,
	output rx_frame_t frame,
	output logic rx_done
);

	logic start;
	logic shift_en;
	logic receiving;
	logic [$clog2(addr_width)-1:0] bit_cnt;
	logic is_read;
	logic is_write;
	logic [addr_width-1:0] addr_sr;
	logic [data_width-1:0] data_sr;
	logic [burst_width-1:0] burst_sr;

	assign start = master_valid & ~busy & (read_en | write_en);
	assign shift_en = receiving | start;	// Start cycle carries bit 0

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			receiving <= 1'b0;
			bit_cnt <= '0;
			is_read <= 1'b0;
			is_write <= 1'b0;
			in_ready <= 1'b1;
			rx_done <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			if (receiving)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == addr_width - 1)
				begin
					receiving <= 1'b0;
					rx_done <= 1'b1;
				end
			end
			else if (start)
			begin
				receiving <= 1'b1;
				bit_cnt <= 1;
				is_read <= read_en;
				is_write <= ~read_en;	// Read wins if both are set
				in_ready <= 1'b0;
			end
			else if (rx_done)
				in_ready <= 1'b1;	// Controller has taken the frame by now
		end
	end

	// LSB arrives first, so new bits enter at the top
	always_ff @(posedge clk)
	begin
		if (shift_en)
		begin
			addr_sr <= {rx_address, addr_sr[addr_width-1:1]};
			burst_sr <= {rx_burst, burst_sr[burst_width-1:1]};
			if (~receiving || bit_cnt < data_width)
				data_sr <= {rx_data, data_sr[data_width-1:1]};
		end
	end

	assign frame = '{address: addr_sr, data: data_sr, burst: burst_sr,
		read: is_read, write: is_write};

endmodule

/* slave_pkg.sv */
// Received frame, memory request and controller state types of the slave
package slave_pkg;
	import bus_pkg::*;

	// One decoded serial frame
	typedef struct packed {
		logic [addr_width-1:0] address;
		logic [data_width-1:0] data;
		logic [burst_width-1:0] burst;
		logic read;
		logic write;
	} rx_frame_t;

	// Memory access, re asks for a registered read of addr
	typedef struct packed {
		logic [addr_width-1:0] addr;
		logic [data_width-1:0] wdata;
		logic we;
		logic re;
	} mem_req_t;

	typedef enum logic [2:0] {
		ctrl_idle,
		ctrl_split,	// Slow read, bus released
		ctrl_fetch,	// Single memory access
		ctrl_valid,	// Byte offered, more beats follow
		ctrl_burst_end	// Last byte offered
	} ctrl_state_t;

endpackage

/* bus_pkg.sv */
// Serial bus field widths, slave delay width and split threshold
package bus_pkg;

	// Serial fields, all sent LSB first
	localparam int addr_width = 12;	// Byte address, 4096 locations
	localparam int data_width = 8;	// Write data and read data
	localparam int burst_width = 12;	// Read burst count, 0 acts as 1

	localparam int delay_width = 6;	// Configured access delay of the slave

	// Reads on a slave at least this slow release the bus while waiting
	localparam int split_threshold = 5;

endpackage
